/* run_sim.sh */
#!/bin/sh
# Build the vector float multiplier testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/10ps \
  --top-module tb_vfmul \
  -f vfmul.f

./obj_dir/Vtb_vfmul | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation passed"

/* src/elem_counter.sv */
/* Remaining-element counter for one vector command.
   Loaded with the length, decremented per accepted result. */

`timescale 1ns/10ps

module elem_counter import vfmul_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  logic     load,
  input  vec_len_t len,
  input  logic     step,
  output logic     last,
  output logic     empty
);

  // Elements still to be delivered
  vec_len_t count;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count <= '0;
    end else if (load) begin
      count <= len;
    end else if (step && (count != '0)) begin
      // Never wraps below zero
      count <= count - 1'b1;
    end
  end

  // Flags follow the register, so they settle the cycle after load or step
  assign last  = (count == vec_len_t'(1));
  assign empty = (count == '0);

endmodule

/* src/fmul_if.sv */
/* Job link between the vector controller and the iterative scalar multiplier.
   The controller connects as issuer and the multiplier as unit. */

`timescale 1ns/10ps

interface fmul_if import vfmul_pkg::*; ();

  // One-cycle job request, operands held until ready
  logic     start;
  fp_word_t op_a;
  fp_word_t op_b;

  // One-cycle completion pulse, product valid alongside
  logic     ready;
  fp_word_t product;

  // Controller side
  modport issuer (
    output start,
    output op_a,
    output op_b,
    input  ready,
    input  product
  );

  // Multiplier side
  modport unit (
    input  start,
    input  op_a,
    input  op_b,
    output ready,
    output product
  );

endinterface

/* src/fp_scalar_mul.sv */
/* Iterative single-precision multiplier, one job at a time.
   Unpack on start, shift-add the mantissas, then normalize, truncate and pack. */

`timescale 1ns/10ps

`include "vfmul_defs.svh"

module fp_scalar_mul import vfmul_pkg::*; (
  input  logic CLK,
  input  logic RST,
  fmul_if.unit mul
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Sequencing
  logic idle;
  logic run;
  logic fin;
  logic [$clog2(`VFMUL_MANT_STEPS)-1:0] step_cnt;

  // Unpacked job
  logic                 sign_r;
  logic                 zero_r;
  logic signed [9:0]    exp_r;

  // Shift-add datapath
  logic [2*`VFMUL_MANT_STEPS-1:0] mcand;
  logic [`VFMUL_MANT_STEPS-1:0]   mplier;
  logic [2*`VFMUL_MANT_STEPS-1:0] acc;

  // Pack stage
  logic              norm_hi;
  logic signed [9:0] exp_adj;
  logic [22:0]       frac;
  fp_word_t          result_word;

  assign idle = !run && !fin;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  // start edge, MANT_STEPS add edges, one pack edge -> ready
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run       <= 1'b0;
      fin       <= 1'b0;
      step_cnt  <= '0;
      mul.ready <= 1'b0;
    end else begin
      mul.ready <= 1'b0;
      if (mul.start && idle) begin
        run      <= 1'b1;
        step_cnt <= '0;
      end else if (run) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == ($clog2(`VFMUL_MANT_STEPS))'(`VFMUL_MANT_STEPS - 1)) begin
          run <= 1'b0;
          fin <= 1'b1;
        end
      end else if (fin) begin
        fin       <= 1'b0;
        mul.ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (mul.start && idle) begin
      sign_r <= mul.op_a[31] ^ mul.op_b[31];
      // Zero or subnormal on either side flushes the product
      zero_r <= (mul.op_a[30:23] == 8'd0) || (mul.op_b[30:23] == 8'd0);
      // Biased sum with one bias removed
      exp_r  <= $signed({2'b00, mul.op_a[30:23]}) + $signed({2'b00, mul.op_b[30:23]})
                - 10'sd127;
      // Hidden bit restored
      mcand  <= {{`VFMUL_MANT_STEPS{1'b0}}, 1'b1, mul.op_a[22:0]};
      mplier <= {1'b1, mul.op_b[22:0]};
      acc    <= '0;
    end else if (run) begin
      // LSB first, multiplicand moves up one place per step
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (fin) begin
      mul.product <= result_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Normalize and pack
  ////////////////////////////////////////////////////////////

  // Product of two [1,2) mantissas lies in [1,4)
  assign norm_hi = acc[2*`VFMUL_MANT_STEPS-1];

  always_comb begin
    exp_adj = exp_r + (norm_hi ? 10'sd1 : 10'sd0);
    // Truncate, bits below the kept fraction dropped
    frac = norm_hi ? acc[2*`VFMUL_MANT_STEPS-2 -: 23] : acc[2*`VFMUL_MANT_STEPS-3 -: 23];
    if (zero_r || (exp_adj <= 10'sd0)) begin
      // Underflow and flushed inputs give signed zero
      result_word = {sign_r, 31'd0};
    end else if (exp_adj >= 10'sd255) begin
      // Overflow saturates to signed infinity
      result_word = {sign_r, 8'hff, 23'd0};
    end else begin
      result_word = {sign_r, exp_adj[7:0], frac};
    end
  end

endmodule

/* src/vfmul_ctrl.sv */
/* Vector controller: pairs A and B words, runs the scalar unit per element
   and offers each product on the result stream until it is taken. */

`timescale 1ns/10ps

module vfmul_ctrl import vfmul_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  // Command
  input  logic     start_cmd,
  input  vec_len_t len,
  output logic     busy,
  output logic     done,
  // Operand streams
  input  logic     a_valid,
  output logic     a_ready,
  input  fp_word_t a_data,
  input  logic     b_valid,
  output logic     b_ready,
  input  fp_word_t b_data,
  // Result stream
  output logic     res_valid,
  input  logic     res_ready,
  output fp_word_t res_data,
  // Element counter
  output logic     cnt_load,
  output vec_len_t cnt_len,
  output logic     cnt_step,
  input  logic     cnt_last,
  input  logic     cnt_empty,
  // Scalar multiplier
  fmul_if.issuer   mul
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ctrl_state_t state;

  // Operand captured for the current element
  logic have_a;
  logic have_b;

  fp_word_t op_a_r;
  fp_word_t op_b_r;
  fp_word_t res_r;

  logic a_fire;
  logic b_fire;
  logic res_fire;

  ////////////////////////////////////////////////////////////
  // Handshakes and decoded outputs
  ////////////////////////////////////////////////////////////

  assign busy = (state != IDLE);

  // Each side closes once its word is held
  assign a_ready = (state == GATHER) && !have_a;
  assign b_ready = (state == GATHER) && !have_b;
  assign a_fire  = a_valid && a_ready;
  assign b_fire  = b_valid && b_ready;

  assign res_valid = (state == EMIT);
  assign res_fire  = res_valid && res_ready;
  assign res_data  = res_r;

  // Counter loads on an accepted command, counts taken results
  assign cnt_load = (state == IDLE) && start_cmd;
  assign cnt_len  = len;
  assign cnt_step = res_fire;

  // Job issue as soon as both operands are in
  assign mul.start = (state == GATHER) && have_a && have_b;
  assign mul.op_a  = op_a_r;
  assign mul.op_b  = op_b_r;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= IDLE;
      have_a <= 1'b0;
      have_b <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start_cmd) begin
            // Empty vector closes at once
            if (len == '0) begin
              done <= 1'b1;
            end else begin
              state <= GATHER;
            end
          end
        end
        GATHER: begin
          if (mul.start) begin
            have_a <= 1'b0;
            have_b <= 1'b0;
            state  <= MULTIPLY;
          end else begin
            if (a_fire) begin
              have_a <= 1'b1;
            end
            if (b_fire) begin
              have_b <= 1'b1;
            end
          end
        end
        MULTIPLY: begin
          if (mul.ready) begin
            state <= EMIT;
          end
        end
        EMIT: begin
          // Back-pressure holds here, no new operands taken
          if (res_fire) begin
            // Last element, or count already drained
            if (cnt_last || cnt_empty) begin
              done  <= 1'b1;
              state <= IDLE;
            end else begin
              state <= GATHER;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand and result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (a_fire) begin
      op_a_r <= a_data;
    end
    if (b_fire) begin
      op_b_r <= b_data;
    end
    // Product kept stable for the whole EMIT stay
    if ((state == MULTIPLY) && mul.ready) begin
      res_r <= mul.product;
    end
  end

endmodule

/* src/vfmul_defs.svh */
/* Width and step-count macros for the vector float multiplier.
   Included by the package and by any RTL file that sizes logic from these values. */

`ifndef VFMUL_DEFS_SVH
`define VFMUL_DEFS_SVH

////////////////////////////////////////////////////////////
// Word and length widths
////////////////////////////////////////////////////////////

// IEEE single-precision word
`define VFMUL_FP_WIDTH 32

// Vector length and element index
`define VFMUL_LEN_WIDTH 16

////////////////////////////////////////////////////////////
// Scalar multiplier
////////////////////////////////////////////////////////////

// One shift-add pass per mantissa bit, hidden bit included
`define VFMUL_MANT_STEPS 24

`endif

/* src/vfmul_pkg.sv */
/* Shared types for the vector float multiplier RTL.
   Imported by wildcard in every module and interface header. */

`include "vfmul_defs.svh"

package vfmul_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // Sign, 8-bit exponent, 23-bit fraction
  typedef logic [`VFMUL_FP_WIDTH-1:0] fp_word_t;

  // Element count of one vector command
  typedef logic [`VFMUL_LEN_WIDTH-1:0] vec_len_t;

  ////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // Waiting for a command
    GATHER   = 2'd1,  // Collecting one A and one B word
    MULTIPLY = 2'd2,  // Scalar unit busy
    EMIT     = 2'd3   // Product offered downstream
  } ctrl_state_t;

endpackage

/* src/vfmul_top.sv */
/* Top level of the vector float multiplier with valid/ready streams.
   Joins the controller, element counter and scalar multiplier. */

`timescale 1ns/10ps

module vfmul_top import vfmul_pkg::*; (
  input  logic     CLK,
  input  logic     RST,
  input  logic     start_cmd,
  input  vec_len_t len,
  output logic     busy,
  output logic     done,
  input  logic     a_valid,
  output logic     a_ready,
  input  fp_word_t a_data,
  input  logic     b_valid,
  output logic     b_ready,
  input  fp_word_t b_data,
  output logic     res_valid,
  input  logic     res_ready,
  output fp_word_t res_data
);

  // Counter link
  logic     cnt_load;
  vec_len_t cnt_len;
  logic     cnt_step;
  logic     cnt_last;
  logic     cnt_empty;

  // Controller to scalar unit
  fmul_if u_mul_if ();

  vfmul_ctrl u_ctrl (
    .CLK       (CLK),
    .RST       (RST),
    .start_cmd (start_cmd),
    .len       (len),
    .busy      (busy),
    .done      (done),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_data    (b_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .cnt_load  (cnt_load),
    .cnt_len   (cnt_len),
    .cnt_step  (cnt_step),
    .cnt_last  (cnt_last),
    .cnt_empty (cnt_empty),
    .mul       (u_mul_if.issuer)
  );

  elem_counter u_cnt (
    .CLK   (CLK),
    .RST   (RST),
    .load  (cnt_load),
    .len   (cnt_len),
    .step  (cnt_step),
    .last  (cnt_last),
    .empty (cnt_empty)
  );

  fp_scalar_mul u_mul (
    .CLK (CLK),
    .RST (RST),
    .mul (u_mul_if.unit)
  );

endmodule

/* tests/tb_fp_model.svh */
/* Reference float product, xorshift generator and operand makers for the testbench.
   Included inside the testbench module body. */

`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// Operand classes
localparam int KIND_NORMAL = 0;
localparam int KIND_FLUSH  = 1;  // exact zero or subnormal
localparam int KIND_TINY   = 2;  // two of these fall below the normal range
localparam int KIND_HUGE   = 3;  // two of these overflow

// Vector flavours
localparam int MODE_NORMAL  = 0;
localparam int MODE_SPECIAL = 1;
localparam int MODE_MIXED   = 2;

// 32-bit xorshift, nonzero state stays nonzero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Single-precision product, truncated toward zero
function automatic logic [31:0] model_fmul(input logic [31:0] a, input logic [31:0] b);
  logic        sign;
  logic [47:0] prod;
  int          exp_sum;
  logic [22:0] frac;
  sign = a[31] ^ b[31];
  // Zero or subnormal input flushes
  if ((a[30:23] == 8'd0) || (b[30:23] == 8'd0)) begin
    return {sign, 31'd0};
  end
  prod    = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
  exp_sum = int'(a[30:23]) + int'(b[30:23]) - 127;
  // Product in [1,4), one shift at most
  if (prod[47]) begin
    exp_sum = exp_sum + 1;
    frac    = prod[46:24];
  end else begin
    frac = prod[45:23];
  end
  if (exp_sum <= 0) begin
    return {sign, 31'd0};
  end
  if (exp_sum >= 255) begin
    return {sign, 8'hff, 23'd0};
  end
  return {sign, exp_sum[7:0], frac};
endfunction

// One operand of the given class from a random word
function automatic logic [31:0] make_operand(input int kind, input logic [31:0] r);
  logic [7:0]  exp_f;
  logic [22:0] frac;
  frac = r[22:0];
  case (kind)
    KIND_FLUSH: begin
      exp_f = 8'd0;
      // Half exact zeros, half subnormals
      if (r[23]) begin
        frac = 23'd0;
      end
    end
    KIND_TINY: exp_f = 8'd1 + {3'd0, r[28:24]};
    KIND_HUGE: exp_f = 8'd222 + {3'd0, r[28:24]};
    default:   exp_f = 8'd64 + {1'b0, r[30:24]};
  endcase
  return {r[31], exp_f, frac};
endfunction

// Operand class per element and side
function automatic int pick_kind(input int mode, input int idx, input bit side_b,
                                 input logic [31:0] r);
  int kind;
  kind = KIND_NORMAL;
  if (mode == MODE_SPECIAL) begin
    case (idx % 4)
      0:       kind = side_b ? KIND_NORMAL : KIND_FLUSH;
      1:       kind = KIND_TINY;
      2:       kind = KIND_HUGE;
      default: kind = side_b ? KIND_FLUSH : KIND_NORMAL;
    endcase
  end else if (mode == MODE_MIXED) begin
    kind = r[2] ? KIND_NORMAL : int'(r[1:0]);
  end
  return kind;
endfunction

`endif

/* tests/tb_vfmul.sv */
/* Self-checking testbench for the vector float multiplier.
   Streams random and corner-case operands with gaps and back-pressure, checks every product. */

`timescale 1ns/10ps

`include "vfmul_defs.svh"

module tb_vfmul;

  `include "tb_fp_model.svh"

  localparam logic [31:0] SEED = 32'hff8a_6497;
  // Elements over all commands below
  localparam int TOTAL_ELEMS = 24 + 12 + 0 + 8 + 40;
  localparam int CYCLE_LIMIT = TOTAL_ELEMS * 40 + 200;
  localparam int NUM_CMDS    = 5;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic                       CLK = 1'b0;
  logic                       RST = 1'b1;
  logic                       start_cmd = 1'b0;
  logic [`VFMUL_LEN_WIDTH-1:0] len = '0;
  logic                       busy;
  logic                       done;
  logic                       a_valid = 1'b0;
  logic                       a_ready;
  logic [`VFMUL_FP_WIDTH-1:0] a_data = '0;
  logic                       b_valid = 1'b0;
  logic                       b_ready;
  logic [`VFMUL_FP_WIDTH-1:0] b_data = '0;
  logic                       res_valid;
  logic                       res_ready = 1'b0;
  logic [`VFMUL_FP_WIDTH-1:0] res_data;

  // Words waiting to be sent and products waiting to be seen
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] exp_q[$];

  logic [31:0] op_rng = SEED;
  logic [31:0] a_rng  = SEED ^ 32'h1357_9bdf;
  logic [31:0] b_rng  = SEED ^ 32'h2468_ace0;
  logic [31:0] r_rng  = SEED ^ 32'h0f0f_3c3c;

  int check_errors = 0;
  int seq_errors   = 0;
  int done_count   = 0;
  int res_count    = 0;
  int res_total    = 0;
  int cycle_count  = 0;

  logic [15:0] cmd_len_r    = '0;
  logic        cmd_pending  = 1'b0;
  logic        done_prev    = 1'b0;
  logic        hold_pending = 1'b0;
  logic [31:0] hold_data    = '0;
  logic        a_went       = 1'b0;
  logic        b_went       = 1'b0;
  logic [31:0] exp_word;

  always #2 CLK = ~CLK;

  vfmul_top u_dut (
    .CLK       (CLK),
    .RST       (RST),
    .start_cmd (start_cmd),
    .len       (len),
    .busy      (busy),
    .done      (done),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_data    (b_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

  ////////////////////////////////////////////////////////////
  // Stream drivers on the falling edge
  ////////////////////////////////////////////////////////////

  // A words with random one-cycle gaps
  always @(negedge CLK) begin
    if (a_went) begin
      a_valid = 1'b0;
    end
    if (!a_valid && (a_q.size() != 0)) begin
      a_rng = xorshift32(a_rng);
      if (a_rng[1:0] != 2'b00) begin
        a_valid = 1'b1;
        a_data  = a_q.pop_front();
      end
    end
  end

  // B words with their own gap sequence
  always @(negedge CLK) begin
    if (b_went) begin
      b_valid = 1'b0;
    end
    if (!b_valid && (b_q.size() != 0)) begin
      b_rng = xorshift32(b_rng);
      if (b_rng[1:0] != 2'b00) begin
        b_valid = 1'b1;
        b_data  = b_q.pop_front();
      end
    end
  end

  // Result back-pressure with ready about five cycles in eight
  always @(negedge CLK) begin
    r_rng     = xorshift32(r_rng);
    res_ready = (r_rng[2:0] > 3'd2);
  end

  ////////////////////////////////////////////////////////////
  // Checker on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    a_went = a_valid && a_ready;
    b_went = b_valid && b_ready;
    if (!RST) begin
      // Busy from the accepted start until done
      if (cmd_pending) begin
        assert (busy || done) else begin
          $display("[FAIL] %0t busy got %b expected 1 until done", $time, busy);
          check_errors++;
        end
      end
      assert (busy || (!a_ready && !b_ready && !res_valid)) else begin
        $display("Stream handshake open at %0t while not busy", $time);
        check_errors++;
      end
      if (done) begin
        assert (cmd_pending && !done_prev) else begin
          $display("Unexpected or stretched done pulse at %0t", $time);
          check_errors++;
        end
        assert ((res_count == int'(cmd_len_r)) && (exp_q.size() == 0)) else begin
          $display("Done at %0t after %0d results, %0d expected", $time, res_count,
                   cmd_len_r);
          check_errors++;
        end
        done_count++;
        cmd_pending = 1'b0;
      end
      done_prev = done;
      // Held result must not move
      if (hold_pending) begin
        assert (res_valid) else begin
          $display("[FAIL] %0t res_valid got %b expected 1 while held", $time, res_valid);
          check_errors++;
        end
        assert (res_data == hold_data) else begin
          $display("[FAIL] %0t res_data held %h changed to %h", $time, hold_data, res_data);
          check_errors++;
        end
      end
      hold_pending = res_valid && !res_ready;
      hold_data    = res_data;
      if (res_valid && res_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("Result at %0t with no product expected", $time);
          check_errors++;
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (res_data == exp_word) else begin
            $display("[FAIL] %0t res_data got %h expected %h", $time, res_data, exp_word);
            check_errors++;
          end
        end
        res_count++;
        res_total++;
      end
      // Start only taken while idle
      if (start_cmd && !busy) begin
        cmd_len_r   = len;
        res_count   = 0;
        cmd_pending = 1'b1;
      end
    end
  end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d results seen", cycle_count, res_total);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  // Control output that must sit low
  task automatic expect_low(input string name, input logic value);
    assert (value === 1'b0) else begin
      $display("[FAIL] %0t %s got %b expected 0", $time, name, value);
      seq_errors++;
    end
  endtask

  // Queue n operand pairs, start the command and wait for its done
  task automatic run_vector(input int n, input int mode, input bit restart_busy);
    int          i;
    int          kind_a;
    int          kind_b;
    int          target;
    logic [31:0] wa;
    logic [31:0] wb;
    for (i = 0; i < n; i++) begin
      op_rng = xorshift32(op_rng);
      kind_a = pick_kind(mode, i, 1'b0, op_rng);
      kind_b = pick_kind(mode, i, 1'b1, op_rng >> 8);
      op_rng = xorshift32(op_rng);
      wa     = make_operand(kind_a, op_rng);
      op_rng = xorshift32(op_rng);
      wb     = make_operand(kind_b, op_rng);
      a_q.push_back(wa);
      b_q.push_back(wb);
      exp_q.push_back(model_fmul(wa, wb));
    end
    target    = done_count + 1;
    start_cmd = 1'b1;
    len       = n[15:0];
    @(negedge CLK);
    start_cmd = 1'b0;
    // Second command while busy must be dropped
    if (restart_busy) begin
      repeat (4) @(negedge CLK);
      assert (busy) else begin
        $display("[FAIL] %0t busy got %b expected 1", $time, busy);
        seq_errors++;
      end
      start_cmd = 1'b1;
      len       = 16'd3;
      @(negedge CLK);
      start_cmd = 1'b0;
    end
    while (done_count < target) begin
      @(negedge CLK);
    end
  endtask

  initial begin
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    expect_low("busy", busy);
    expect_low("done", done);
    expect_low("a_ready", a_ready);
    expect_low("b_ready", b_ready);
    expect_low("res_valid", res_valid);

    run_vector(24, MODE_NORMAL, 1'b0);
    run_vector(12, MODE_SPECIAL, 1'b0);
    run_vector(0, MODE_NORMAL, 1'b0);
    run_vector(8, MODE_MIXED, 1'b1);
    run_vector(40, MODE_MIXED, 1'b0);
    repeat (5) @(negedge CLK);

    assert (done_count == NUM_CMDS) else begin
      $display("Saw %0d done pulses for %0d commands", done_count, NUM_CMDS);
      seq_errors++;
    end
    assert ((exp_q.size() == 0) && (a_q.size() == 0) && (b_q.size() == 0)) else begin
      $display("Words left over at the end of the run");
      seq_errors++;
    end

    $display("Summary: check errors %0d, sequence errors %0d, commands %0d, results %0d",
             check_errors, seq_errors, done_count, res_total);
    if ((check_errors == 0) && (seq_errors == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* vfmul.f */
+incdir+src
+incdir+tests
src/vfmul_pkg.sv
src/fmul_if.sv
src/vfmul_ctrl.sv
src/elem_counter.sv
src/fp_scalar_mul.sv
src/vfmul_top.sv
tests/tb_vfmul.sv
